// ==== common/id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [2:0]  alu_cat_t;

    localparam word_t ZERO_WORD = 32'h0000_0000;

    // Major opcodes, instruction[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;

    // Function codes of SPECIAL, instruction[5:0]
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_MOVZ = 6'b001010;

    // Operators seen by the execute stage, immediate forms share the register ones
    localparam alu_op_t OP_NOP  = 8'b0000_0000;
    localparam alu_op_t OP_OR   = 8'b0010_0101;
    localparam alu_op_t OP_AND  = 8'b0010_0100;
    localparam alu_op_t OP_XOR  = 8'b0010_0110;
    localparam alu_op_t OP_NOR  = 8'b0010_0111;
    localparam alu_op_t OP_LUI  = 8'b0101_1100;
    localparam alu_op_t OP_SLL  = 8'b0111_1100;
    localparam alu_op_t OP_SRL  = 8'b0000_0010;
    localparam alu_op_t OP_SRA  = 8'b0000_0011;
    localparam alu_op_t OP_ADD  = 8'b0010_0000;
    localparam alu_op_t OP_ADDU = 8'b0010_0001;
    localparam alu_op_t OP_SUB  = 8'b0010_0010;
    localparam alu_op_t OP_SUBU = 8'b0010_0011;
    localparam alu_op_t OP_SLT  = 8'b0010_1010;
    localparam alu_op_t OP_SLTU = 8'b0010_1011;
    localparam alu_op_t OP_MOVN = 8'b0000_1011;
    localparam alu_op_t OP_MOVZ = 8'b0000_1010;

    // Result categories for the execute-stage result mux
    localparam alu_cat_t CAT_NOP   = 3'b000;
    localparam alu_cat_t CAT_LOGIC = 3'b001;
    localparam alu_cat_t CAT_SHIFT = 3'b010;
    localparam alu_cat_t CAT_MOVE  = 3'b011;
    localparam alu_cat_t CAT_ARITH = 3'b100;

endpackage

`default_nettype wire

// ==== common/decode_if.sv ====
`default_nettype none

interface decode_if;

    logic               read_enable1;
    logic               read_enable2;
    id_pkg::reg_addr_t  read_addr1;
    id_pkg::reg_addr_t  read_addr2;
    id_pkg::alu_op_t    alu_operator;
    id_pkg::alu_cat_t   alu_category;
    logic               write_enable;
    id_pkg::reg_addr_t  write_addr;
    logic               cond_move;      // Write depends on the rt value
    logic               move_on_zero;   // Movz rather than movn
    id_pkg::word_t      imm;
    logic               invalid_inst;

    modport decoder (
        output read_enable1, read_enable2, read_addr1, read_addr2,
        output alu_operator, alu_category, write_enable, write_addr,
        output cond_move, move_on_zero, imm, invalid_inst
    );

    modport operand (
        input read_enable1, read_enable2, read_addr1, read_addr2,
        input alu_operator, alu_category, write_enable, write_addr,
        input cond_move, move_on_zero, imm, invalid_inst
    );

endinterface

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  logic            rst_n,
    input  id_pkg::inst_t   instruction,
    decode_if.decoder       dec
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    id_pkg::reg_addr_t  rs;
    id_pkg::reg_addr_t  rt;
    id_pkg::reg_addr_t  rd;
    logic [4:0]         sa;
    logic [15:0]        imm16;

    logic               re1;
    logic               re2;
    logic               dest_rt;
    logic               valid;
    logic               fixed_shift;
    logic               cond;
    logic               on_zero;
    id_pkg::alu_op_t    op;
    id_pkg::alu_cat_t   cat;
    id_pkg::word_t      imm;

    assign opcode = instruction[31:26];
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign sa     = instruction[10:6];
    assign funct  = instruction[5:0];
    assign imm16  = instruction[15:0];

    always_comb begin
        re1         = 1'b1;
        re2         = 1'b1;
        dest_rt     = 1'b0;
        valid       = 1'b1;
        fixed_shift = 1'b0;
        cond        = 1'b0;
        on_zero     = 1'b0;
        op          = id_pkg::OP_NOP;
        cat         = id_pkg::CAT_NOP;
        imm         = id_pkg::ZERO_WORD;
        case (opcode)
            id_pkg::OPC_SPECIAL: begin
                case (funct)
                    id_pkg::FN_OR:   begin op = id_pkg::OP_OR;   cat = id_pkg::CAT_LOGIC; end
                    id_pkg::FN_AND:  begin op = id_pkg::OP_AND;  cat = id_pkg::CAT_LOGIC; end
                    id_pkg::FN_XOR:  begin op = id_pkg::OP_XOR;  cat = id_pkg::CAT_LOGIC; end
                    id_pkg::FN_NOR:  begin op = id_pkg::OP_NOR;  cat = id_pkg::CAT_LOGIC; end
                    id_pkg::FN_SLLV: begin op = id_pkg::OP_SLL;  cat = id_pkg::CAT_SHIFT; end
                    id_pkg::FN_SRLV: begin op = id_pkg::OP_SRL;  cat = id_pkg::CAT_SHIFT; end
                    id_pkg::FN_SRAV: begin op = id_pkg::OP_SRA;  cat = id_pkg::CAT_SHIFT; end
                    id_pkg::FN_ADD:  begin op = id_pkg::OP_ADD;  cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_ADDU: begin op = id_pkg::OP_ADDU; cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_SUB:  begin op = id_pkg::OP_SUB;  cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_SUBU: begin op = id_pkg::OP_SUBU; cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_SLT:  begin op = id_pkg::OP_SLT;  cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_SLTU: begin op = id_pkg::OP_SLTU; cat = id_pkg::CAT_ARITH; end
                    id_pkg::FN_MOVN: begin
                        op   = id_pkg::OP_MOVN;
                        cat  = id_pkg::CAT_MOVE;
                        cond = 1'b1;
                    end
                    id_pkg::FN_MOVZ: begin
                        op      = id_pkg::OP_MOVZ;
                        cat     = id_pkg::CAT_MOVE;
                        cond    = 1'b1;
                        on_zero = 1'b1;
                    end
                    id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
                        fixed_shift = 1'b1;
                        re1         = 1'b0;            // Operand1 takes sa instead of rs
                        cat         = id_pkg::CAT_SHIFT;
                        imm         = {27'd0, sa};
                        if (funct == id_pkg::FN_SLL) begin
                            op = id_pkg::OP_SLL;
                        end else if (funct == id_pkg::FN_SRL) begin
                            op = id_pkg::OP_SRL;
                        end else begin
                            op = id_pkg::OP_SRA;
                        end
                    end
                    default: valid = 1'b0;
                endcase
                // Fixed shifts need rs zero, every other SPECIAL form needs sa zero
                if (fixed_shift ? (rs != 5'd0) : (sa != 5'd0)) begin
                    valid = 1'b0;
                end
            end
            id_pkg::OPC_ORI, id_pkg::OPC_ANDI, id_pkg::OPC_XORI: begin
                re2     = 1'b0;
                dest_rt = 1'b1;
                cat     = id_pkg::CAT_LOGIC;
                imm     = {16'h0000, imm16};
                if (opcode == id_pkg::OPC_ORI) begin
                    op = id_pkg::OP_OR;
                end else if (opcode == id_pkg::OPC_ANDI) begin
                    op = id_pkg::OP_AND;
                end else begin
                    op = id_pkg::OP_XOR;
                end
            end
            id_pkg::OPC_LUI: begin
                re2     = 1'b0;
                dest_rt = 1'b1;
                op      = id_pkg::OP_LUI;
                cat     = id_pkg::CAT_LOGIC;
                imm     = {imm16, 16'h0000};
            end
            id_pkg::OPC_ADDI, id_pkg::OPC_ADDIU, id_pkg::OPC_SLTI, id_pkg::OPC_SLTIU: begin
                re2     = 1'b0;
                dest_rt = 1'b1;
                cat     = id_pkg::CAT_ARITH;
                imm     = {{16{imm16[15]}}, imm16};
                case (opcode)
                    id_pkg::OPC_ADDI:  op = id_pkg::OP_ADD;
                    id_pkg::OPC_ADDIU: op = id_pkg::OP_ADDU;
                    id_pkg::OPC_SLTI:  op = id_pkg::OP_SLT;
                    default:           op = id_pkg::OP_SLTU;
                endcase
            end
            default: valid = 1'b0;
        endcase
        if (!valid) begin
            re1  = 1'b0;
            re2  = 1'b0;
            cond = 1'b0;
            op   = id_pkg::OP_NOP;
            cat  = id_pkg::CAT_NOP;
        end
    end

    assign dec.read_enable1 = rst_n & re1;
    assign dec.read_enable2 = rst_n & re2;
    assign dec.read_addr1   = rs;
    assign dec.read_addr2   = rt;
    assign dec.alu_operator = op;
    assign dec.alu_category = cat;
    assign dec.write_enable = rst_n & valid;
    assign dec.write_addr   = dest_rt ? rt : rd;
    assign dec.cond_move    = cond;
    assign dec.move_on_zero = on_zero;
    assign dec.imm          = imm;
    assign dec.invalid_inst = rst_n & ~valid;

endmodule

`default_nettype wire

// ==== decode/operand_stage.sv ====
`default_nettype none

module operand_stage (
    input  logic                clk,
    input  logic                rst_n,
    decode_if.operand           dec,
    input  logic                ex_write_enable,
    input  id_pkg::reg_addr_t   ex_write_addr,
    input  id_pkg::word_t       ex_write_data,
    input  logic                mem_write_enable,
    input  id_pkg::reg_addr_t   mem_write_addr,
    input  id_pkg::word_t       mem_write_data,
    input  id_pkg::word_t       read_result1,
    input  id_pkg::word_t       read_result2,
    output id_pkg::alu_op_t     alu_operator,
    output id_pkg::alu_cat_t    alu_category,
    output id_pkg::word_t       alu_operand1,
    output id_pkg::word_t       alu_operand2,
    output logic                write_enable,
    output id_pkg::reg_addr_t   write_addr,
    output logic                invalid_inst
);

    id_pkg::word_t  operand1;
    id_pkg::word_t  operand2;
    logic           move_ok;
    logic           write_next;

    // Newest result wins: execute, then memory, then register file
    function automatic id_pkg::word_t select_operand(
        input logic              read_enable,
        input id_pkg::reg_addr_t read_addr,
        input id_pkg::word_t     read_result,
        input id_pkg::word_t     imm
    );
        if (!read_enable) begin
            return imm;
        end else if (ex_write_enable && ex_write_addr == read_addr) begin
            return ex_write_data;
        end else if (mem_write_enable && mem_write_addr == read_addr) begin
            return mem_write_data;
        end
        return read_result;
    endfunction

    always_comb begin
        operand1 = select_operand(dec.read_enable1, dec.read_addr1, read_result1, dec.imm);
        operand2 = select_operand(dec.read_enable2, dec.read_addr2, read_result2, dec.imm);
    end

    // Movn writes on a non-zero rt value, movz on zero
    assign move_ok    = dec.move_on_zero ? (operand2 == id_pkg::ZERO_WORD)
                                         : (operand2 != id_pkg::ZERO_WORD);
    assign write_next = dec.write_enable & (~dec.cond_move | move_ok);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_operator <= id_pkg::OP_NOP;
            alu_category <= id_pkg::CAT_NOP;
            alu_operand1 <= id_pkg::ZERO_WORD;
            alu_operand2 <= id_pkg::ZERO_WORD;
            write_enable <= 1'b0;
            write_addr   <= 5'd0;
            invalid_inst <= 1'b0;
        end else begin
            alu_operator <= dec.alu_operator;
            alu_category <= dec.alu_category;
            alu_operand1 <= operand1;
            alu_operand2 <= operand2;
            write_enable <= write_next;
            write_addr   <= dec.write_addr;
            invalid_inst <= dec.invalid_inst;
        end
    end

endmodule

`default_nettype wire

// ==== source/id_top.sv ====
`default_nettype none

module id_top (
    input  logic                clk,
    input  logic                rst_n,
    input  id_pkg::inst_t       instruction,
    input  logic                ex_write_enable,
    input  id_pkg::reg_addr_t   ex_write_addr,
    input  id_pkg::word_t       ex_write_data,
    input  logic                mem_write_enable,
    input  id_pkg::reg_addr_t   mem_write_addr,
    input  id_pkg::word_t       mem_write_data,
    input  id_pkg::word_t       read_result1,
    input  id_pkg::word_t       read_result2,
    output logic                read_enable1,
    output logic                read_enable2,
    output id_pkg::reg_addr_t   read_addr1,
    output id_pkg::reg_addr_t   read_addr2,
    output id_pkg::alu_op_t     alu_operator,
    output id_pkg::alu_cat_t    alu_category,
    output id_pkg::word_t       alu_operand1,
    output id_pkg::word_t       alu_operand2,
    output logic                write_enable,
    output id_pkg::reg_addr_t   write_addr,
    output logic                invalid_inst
);

    decode_if dec_bus ();

    inst_decoder u_decoder (
        .rst_n       (rst_n),
        .instruction (instruction),
        .dec         (dec_bus.decoder)
    );

    // Register file sits outside and answers in the same cycle
    assign read_enable1 = dec_bus.read_enable1;
    assign read_enable2 = dec_bus.read_enable2;
    assign read_addr1   = dec_bus.read_addr1;
    assign read_addr2   = dec_bus.read_addr2;

    operand_stage u_operand (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec              (dec_bus.operand),
        .ex_write_enable  (ex_write_enable),
        .ex_write_addr    (ex_write_addr),
        .ex_write_data    (ex_write_data),
        .mem_write_enable (mem_write_enable),
        .mem_write_addr   (mem_write_addr),
        .mem_write_data   (mem_write_data),
        .read_result1     (read_result1),
        .read_result2     (read_result2),
        .alu_operator     (alu_operator),
        .alu_category     (alu_category),
        .alu_operand1     (alu_operand1),
        .alu_operand2     (alu_operand2),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .invalid_inst     (invalid_inst)
    );

endmodule

`default_nettype wire

// ==== sim/id_asserts.sv ====
`default_nettype none

module id_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                read_enable1,
    input  logic                read_enable2,
    input  id_pkg::reg_addr_t   read_addr1,
    input  logic                ex_write_enable,
    input  id_pkg::reg_addr_t   ex_write_addr,
    input  id_pkg::word_t       ex_write_data,
    input  id_pkg::word_t       alu_operand1,
    input  logic                write_enable,
    input  logic                invalid_inst
);

    int failures = 0;

    invalid_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        invalid_inst |-> !write_enable)
    else begin
        failures++;
        $error("invalid_inst is high while write_enable is high");
    end

    reads_off_in_reset: assert property (@(posedge clk)
        !rst_n |-> !read_enable1 && !read_enable2)
    else begin
        failures++;
        $error("A read enable is high during reset");
    end

    ex_forward_port1: assert property (@(posedge clk) disable iff (!rst_n)
        read_enable1 && ex_write_enable && ex_write_addr == read_addr1
        |=> alu_operand1 == $past(ex_write_data))
    else begin
        failures++;
        $error("alu_operand1 did not take the forwarded execute result");
    end

endmodule

bind id_top id_asserts u_asserts (.*);

`default_nettype wire

// ==== sim/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// Newest producer wins: execute, then memory, then the register file
function automatic id_pkg::word_t forwarded(input id_pkg::reg_addr_t addr);
    if (ex_write_enable && ex_write_addr == addr) begin
        return ex_write_data;
    end
    if (mem_write_enable && mem_write_addr == addr) begin
        return mem_write_data;
    end
    return regfile[addr];
endfunction

// Operator in the upper bits and category in the low three, all zero when reserved
function automatic logic [10:0] kind_of(input id_pkg::inst_t inst);
    if (inst[31:26] == id_pkg::OPC_SPECIAL) begin
        case (inst[5:0])
            id_pkg::FN_OR:   return {id_pkg::OP_OR, id_pkg::CAT_LOGIC};
            id_pkg::FN_AND:  return {id_pkg::OP_AND, id_pkg::CAT_LOGIC};
            id_pkg::FN_XOR:  return {id_pkg::OP_XOR, id_pkg::CAT_LOGIC};
            id_pkg::FN_NOR:  return {id_pkg::OP_NOR, id_pkg::CAT_LOGIC};
            id_pkg::FN_SLL:  return {id_pkg::OP_SLL, id_pkg::CAT_SHIFT};
            id_pkg::FN_SRL:  return {id_pkg::OP_SRL, id_pkg::CAT_SHIFT};
            id_pkg::FN_SRA:  return {id_pkg::OP_SRA, id_pkg::CAT_SHIFT};
            id_pkg::FN_SLLV: return {id_pkg::OP_SLL, id_pkg::CAT_SHIFT};
            id_pkg::FN_SRLV: return {id_pkg::OP_SRL, id_pkg::CAT_SHIFT};
            id_pkg::FN_SRAV: return {id_pkg::OP_SRA, id_pkg::CAT_SHIFT};
            id_pkg::FN_ADD:  return {id_pkg::OP_ADD, id_pkg::CAT_ARITH};
            id_pkg::FN_ADDU: return {id_pkg::OP_ADDU, id_pkg::CAT_ARITH};
            id_pkg::FN_SUB:  return {id_pkg::OP_SUB, id_pkg::CAT_ARITH};
            id_pkg::FN_SUBU: return {id_pkg::OP_SUBU, id_pkg::CAT_ARITH};
            id_pkg::FN_SLT:  return {id_pkg::OP_SLT, id_pkg::CAT_ARITH};
            id_pkg::FN_SLTU: return {id_pkg::OP_SLTU, id_pkg::CAT_ARITH};
            id_pkg::FN_MOVN: return {id_pkg::OP_MOVN, id_pkg::CAT_MOVE};
            id_pkg::FN_MOVZ: return {id_pkg::OP_MOVZ, id_pkg::CAT_MOVE};
            default:         return 11'd0;
        endcase
    end
    case (inst[31:26])
        id_pkg::OPC_ORI:   return {id_pkg::OP_OR, id_pkg::CAT_LOGIC};
        id_pkg::OPC_ANDI:  return {id_pkg::OP_AND, id_pkg::CAT_LOGIC};
        id_pkg::OPC_XORI:  return {id_pkg::OP_XOR, id_pkg::CAT_LOGIC};
        id_pkg::OPC_LUI:   return {id_pkg::OP_LUI, id_pkg::CAT_LOGIC};
        id_pkg::OPC_ADDI:  return {id_pkg::OP_ADD, id_pkg::CAT_ARITH};
        id_pkg::OPC_ADDIU: return {id_pkg::OP_ADDU, id_pkg::CAT_ARITH};
        id_pkg::OPC_SLTI:  return {id_pkg::OP_SLT, id_pkg::CAT_ARITH};
        id_pkg::OPC_SLTIU: return {id_pkg::OP_SLTU, id_pkg::CAT_ARITH};
        default:           return 11'd0;
    endcase
endfunction

task automatic predict(input id_pkg::inst_t inst);
    logic        special;
    logic        fixed_shift;
    logic [10:0] kind;
    special     = inst[31:26] == id_pkg::OPC_SPECIAL;
    fixed_shift = special && inst[5:2] == 4'b0000;
    kind        = kind_of(inst);
    // MIPS keeps rs zero in fixed shifts and sa zero in the other SPECIAL forms
    if (special && (fixed_shift ? inst[25:21] != 5'd0 : inst[10:6] != 5'd0)) begin
        kind = 11'd0;
    end
    {exp_op, exp_cat} = kind;
    exp_invalid = kind == 11'd0;
    exp_re1     = !exp_invalid && !fixed_shift;
    exp_re2     = !exp_invalid && special;
    exp_ra1     = inst[25:21];
    exp_ra2     = inst[20:16];
    exp_op1     = fixed_shift ? {27'd0, inst[10:6]} : forwarded(inst[25:21]);
    exp_waddr   = special ? inst[15:11] : inst[20:16];
    if (special) begin
        exp_op2 = forwarded(inst[20:16]);
    end else if (inst[31:26] == id_pkg::OPC_LUI) begin
        exp_op2 = {inst[15:0], 16'h0000};
    end else if (exp_cat == id_pkg::CAT_LOGIC) begin
        exp_op2 = {16'h0000, inst[15:0]};
    end else begin
        exp_op2 = {{16{inst[15]}}, inst[15:0]};
    end
    exp_we = !exp_invalid;
    if (exp_cat == id_pkg::CAT_MOVE) begin
        exp_we = (exp_op == id_pkg::OP_MOVZ) == (exp_op2 == id_pkg::ZERO_WORD);
    end
endtask

`endif

// ==== sim/id_tb.sv ====
`default_nettype none

module id_tb;

    localparam int NUM_TESTS = 3000;
    localparam int PERIOD    = 20;

    logic               clk;
    logic               rst_n;
    id_pkg::inst_t      instruction;
    logic               ex_write_enable;
    id_pkg::reg_addr_t  ex_write_addr;
    id_pkg::word_t      ex_write_data;
    logic               mem_write_enable;
    id_pkg::reg_addr_t  mem_write_addr;
    id_pkg::word_t      mem_write_data;
    id_pkg::word_t      read_result1;
    id_pkg::word_t      read_result2;
    logic               read_enable1;
    logic               read_enable2;
    id_pkg::reg_addr_t  read_addr1;
    id_pkg::reg_addr_t  read_addr2;
    id_pkg::alu_op_t    alu_operator;
    id_pkg::alu_cat_t   alu_category;
    id_pkg::word_t      alu_operand1;
    id_pkg::word_t      alu_operand2;
    logic               write_enable;
    id_pkg::reg_addr_t  write_addr;
    logic               invalid_inst;

    id_pkg::word_t      regfile [0:31];
    logic [5:0]         special_fn [0:17];
    logic [5:0]         imm_opc [0:7];
    string              test_name;

    // Prediction for the inputs applied on the last falling edge
    logic               exp_re1;
    logic               exp_re2;
    id_pkg::reg_addr_t  exp_ra1;
    id_pkg::reg_addr_t  exp_ra2;
    id_pkg::alu_op_t    exp_op;
    id_pkg::alu_cat_t   exp_cat;
    id_pkg::word_t      exp_op1;
    id_pkg::word_t      exp_op2;
    logic               exp_we;
    id_pkg::reg_addr_t  exp_waddr;
    logic               exp_invalid;

    `include "id_model.svh"

    assign read_result1 = regfile[read_addr1];  // Register file answers in the same cycle
    assign read_result2 = regfile[read_addr2];

    id_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_TESTS + 10) * PERIOD);
        $display("Timeout: the run did not reach its end in the expected time");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    always @(UUT.u_asserts.failures) begin
        if (UUT.u_asserts.failures != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("Test failed");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    task automatic mismatch(input string field, input string expected, input string actual);
        $display("** Error %s %s: expected %s, actual %s", test_name, field, expected, actual);
        $display("Test failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_word(input string f, input id_pkg::word_t e, input id_pkg::word_t a);
        if (a !== e) mismatch(f, $sformatf("%h", e), $sformatf("%h", a));
    endtask

    task automatic check_addr(input string f, input id_pkg::reg_addr_t e,
                              input id_pkg::reg_addr_t a);
        if (a !== e) mismatch(f, $sformatf("%0d", e), $sformatf("%0d", a));
    endtask

    task automatic check_op(input string f, input id_pkg::alu_op_t e, input id_pkg::alu_op_t a);
        if (a !== e) mismatch(f, $sformatf("%b", e), $sformatf("%b", a));
    endtask

    task automatic check_cat(input string f, input id_pkg::alu_cat_t e,
                             input id_pkg::alu_cat_t a);
        if (a !== e) mismatch(f, $sformatf("%b", e), $sformatf("%b", a));
    endtask

    task automatic check_bit(input string f, input logic e, input logic a);
        if (a !== e) mismatch(f, $sformatf("%b", e), $sformatf("%b", a));
    endtask

    task automatic check_outputs();
        check_bit("read_enable1", exp_re1, read_enable1);
        check_bit("read_enable2", exp_re2, read_enable2);
        check_addr("read_addr1", exp_ra1, read_addr1);
        check_addr("read_addr2", exp_ra2, read_addr2);
        check_op("alu_operator", exp_op, alu_operator);
        check_cat("alu_category", exp_cat, alu_category);
        check_bit("write_enable", exp_we, write_enable);
        check_bit("invalid_inst", exp_invalid, invalid_inst);
        if (!exp_invalid) begin     // Operands of a reserved instruction carry no meaning
            check_word("alu_operand1", exp_op1, alu_operand1);
            check_word("alu_operand2", exp_op2, alu_operand2);
            check_addr("write_addr", exp_waddr, write_addr);
        end
    endtask

    task automatic expect_reset();
        exp_re1     = 1'b0;
        exp_re2     = 1'b0;
        exp_ra1     = instruction[25:21];
        exp_ra2     = instruction[20:16];
        exp_op      = id_pkg::OP_NOP;
        exp_cat     = id_pkg::CAT_NOP;
        exp_op1     = id_pkg::ZERO_WORD;
        exp_op2     = id_pkg::ZERO_WORD;
        exp_we      = 1'b0;
        exp_waddr   = 5'd0;
        exp_invalid = 1'b0;
    endtask

    // Forwarding targets mostly hit the registers the instruction reads
    function automatic id_pkg::reg_addr_t aim_addr();
        case ($urandom_range(0, 2))
            0:       return instruction[25:21];
            1:       return instruction[20:16];
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic id_pkg::word_t random_data();
        return ($urandom_range(0, 3) == 0) ? id_pkg::ZERO_WORD : id_pkg::word_t'($urandom);
    endfunction

    task automatic apply_inputs();
        int pick;
        pick = $urandom_range(0, 99);
        if (pick < 60) begin
            instruction = {id_pkg::OPC_SPECIAL, 15'($urandom), 5'd0,
                           special_fn[$urandom_range(0, 17)]};
            if (instruction[5:2] == 4'b0000) begin
                instruction[25:21] = 5'd0;
                instruction[10:6]  = 5'($urandom);
            end
        end else if (pick < 88) begin
            instruction = {imm_opc[$urandom_range(0, 7)], 26'($urandom)};
        end else if (pick < 94) begin
            instruction = {id_pkg::OPC_SPECIAL, 26'($urandom)};    // Mostly reserved
        end else begin
            instruction = $urandom;
        end
        ex_write_enable  = $urandom_range(0, 1);
        ex_write_addr    = aim_addr();
        ex_write_data    = random_data();
        mem_write_enable = $urandom_range(0, 1);
        mem_write_addr   = aim_addr();
        mem_write_data   = random_data();
        regfile[$urandom_range(0, 31)] = random_data();
    endtask

    initial begin
        int i;
        void'($urandom(32'hf726));
        special_fn = '{id_pkg::FN_OR, id_pkg::FN_AND, id_pkg::FN_XOR, id_pkg::FN_NOR,
                       id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA, id_pkg::FN_SLLV,
                       id_pkg::FN_SRLV, id_pkg::FN_SRAV, id_pkg::FN_ADD, id_pkg::FN_ADDU,
                       id_pkg::FN_SUB, id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU,
                       id_pkg::FN_MOVN, id_pkg::FN_MOVZ};
        imm_opc    = '{id_pkg::OPC_ORI, id_pkg::OPC_ANDI, id_pkg::OPC_XORI, id_pkg::OPC_LUI,
                       id_pkg::OPC_ADDI, id_pkg::OPC_ADDIU, id_pkg::OPC_SLTI, id_pkg::OPC_SLTIU};
        for (i = 0; i < 32; i++) begin
            regfile[i] = random_data();
        end
        rst_n            = 1'b0;
        instruction      = 32'h0000_0000;
        ex_write_enable  = 1'b0;
        ex_write_addr    = 5'd0;
        ex_write_data    = id_pkg::ZERO_WORD;
        mem_write_enable = 1'b0;
        mem_write_addr   = 5'd0;
        mem_write_data   = id_pkg::ZERO_WORD;
        test_name        = "reset";
        expect_reset();
        repeat (3) begin
            @(negedge clk);
            check_outputs();
            apply_inputs();
            expect_reset();
        end
        rst_n = 1'b1;
        predict(instruction);
        for (i = 0; i < NUM_TESTS; i++) begin
            @(negedge clk);
            test_name = $sformatf("cycle %0d", i);
            check_outputs();
            apply_inputs();
            predict(instruction);
        end
        if (UUT.u_asserts.failures == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Assertion failures: %0d", UUT.u_asserts.failures);
            $display("Test failed");
            $fatal(1, "Assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+sim
common/id_pkg.sv
common/decode_if.sv
decode/inst_decoder.sv
decode/operand_stage.sv
source/id_top.sv
sim/id_asserts.sv
sim/id_tb.sv
